// File: filelist.f
verilog/ns_pkg.sv
verilog/ns_chnl_receiver.sv
verilog/ns_msg_fifo.sv
verilog/nd_2to1.sv
verilog/ns_node_top.sv
tb/tb_clock.sv
tb/tb_ns_node.sv

// File: Bender.yml
package:
  name: ns_node

sources:
  - verilog/ns_pkg.sv
  - verilog/ns_chnl_receiver.sv
  - verilog/ns_msg_fifo.sv
  - verilog/nd_2to1.sv
  - verilog/ns_node_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/tb_ns_node.sv

// File: tb/tb_ns_node.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ns_node;

	localparam int REQ_CKS = ns_pkg::NS_REQ_CKS;
	localparam int ACK_CKS = ns_pkg::NS_ACK_CKS;
	localparam int FSZ = ns_pkg::NS_FIFO_DEPTH;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_MSGS = 19; // Messages delivered over all tests.
	localparam int MSG_CYCLES = (REQ_CKS + ACK_CKS + 20) * 8;

	typedef logic [27:0] msg_t; // {addr, data, redun}

	logic gch_clk, gch_reset;
	logic rcv0_req, rcv1_req, rcv0_ack, rcv1_ack;
	ns_pkg::ns_addr_t rcv0_addr, rcv1_addr, snd0_addr;
	ns_pkg::ns_data_t rcv0_data, rcv1_data, snd0_data;
	ns_pkg::ns_redun_t rcv0_redun, rcv1_redun, snd0_redun;
	logic snd0_req, snd0_ack, gch_ready;

	logic [31:0] lfsr = 32'h9e6a_b376;
	msg_t exp0[$];
	msg_t exp1[$];
	msg_t out_q[$];
	int done_cnt[2];
	int sink_delay;
	logic sink_stall;

	tb_clock #(.PERIOD(20), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.gch_clk (gch_clk),
		.gch_reset (gch_reset)
	);

	ns_node_top #(.REQ_CKS(REQ_CKS), .ACK_CKS(ACK_CKS), .FSZ(FSZ)) uut (
		.gch_clk (gch_clk), .gch_reset (gch_reset),
		.rcv0_req (rcv0_req), .rcv0_addr (rcv0_addr), .rcv0_data (rcv0_data),
		.rcv0_redun (rcv0_redun), .rcv0_ack (rcv0_ack),
		.rcv1_req (rcv1_req), .rcv1_addr (rcv1_addr), .rcv1_data (rcv1_data),
		.rcv1_redun (rcv1_redun), .rcv1_ack (rcv1_ack),
		.snd0_req (snd0_req), .snd0_addr (snd0_addr), .snd0_data (snd0_data),
		.snd0_redun (snd0_redun), .snd0_ack (snd0_ack), .gch_ready (gch_ready)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s (got %h, expected %h)", $time, what, got, exp);
			abort_run("Stopping at the first mismatch.");
		end
	endtask

	// Galois LFSR, one step for every bit handed out.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic ack_of(input int src);
		return (src == 0) ? rcv0_ack : rcv1_ack;
	endfunction

	// Address bit 7 carries the source number.
	task automatic make_msgs(input int src, input int n);
		msg_t m;
		logic [6:0] a;
		logic [15:0] d;
		logic [3:0] r;
		int k;
		for (k = 0; k < n; k++) begin
			a = 7'(rand_bits(7));
			d = 16'(rand_bits(16));
			r = 4'(rand_bits(4));
			m = {src[0], a, d, r};
			if (src == 0)
				exp0.push_back(m);
			else
				exp1.push_back(m);
		end
	endtask

	task automatic drive_msg(input int src, input msg_t m);
		@(posedge gch_clk);
		if (src == 0) begin
			rcv0_addr <= m[27:20];
			rcv0_data <= m[19:4];
			rcv0_redun <= m[3:0];
		end else begin
			rcv1_addr <= m[27:20];
			rcv1_data <= m[19:4];
			rcv1_redun <= m[3:0];
		end
		@(posedge gch_clk);
		if (src == 0)
			rcv0_req <= 1'b1;
		else
			rcv1_req <= 1'b1;
		do @(posedge gch_clk); while (!ack_of(src));
		if (src == 0)
			rcv0_req <= 1'b0;
		else
			rcv1_req <= 1'b0;
		do @(posedge gch_clk); while (ack_of(src));
		done_cnt[src]++;
	endtask

	task automatic send_queue(input int src, input int n);
		int k;
		for (k = 0; k < n; k++)
			drive_msg(src, (src == 0) ? exp0[k] : exp1[k]);
	endtask

	// One output handshake; the message is recorded when it is acknowledged.
	task automatic sink_one();
		repeat (sink_delay) @(posedge gch_clk);
		out_q.push_back({snd0_addr, snd0_data, snd0_redun});
		snd0_ack <= 1'b1;
		do @(posedge gch_clk); while (snd0_req);
		snd0_ack <= 1'b0;
	endtask

	task automatic wait_outputs(input int n);
		int waited;
		waited = 0;
		while (out_q.size() < n) begin
			@(posedge gch_clk);
			waited++;
			if (waited > n * MSG_CYCLES)
				abort_run($sformatf("Output sink got only %0d of %0d messages in time.",
					out_q.size(), n));
		end
	endtask

	task automatic check_by_source();
		int i, n0, n1;
		n0 = 0;
		n1 = 0;
		for (i = 0; i < out_q.size(); i++) begin
			if (out_q[i][27] == 1'b0) begin
				check_eq(out_q[i], exp0[n0], $sformatf("message %0d from input 0", n0));
				n0++;
			end else begin
				check_eq(out_q[i], exp1[n1], $sformatf("message %0d from input 1", n1));
				n1++;
			end
		end
		check_eq(n0, exp0.size(), "count of messages from input 0");
		check_eq(n1, exp1.size(), "count of messages from input 1");
	endtask

	task automatic clear_test();
		exp0.delete();
		exp1.delete();
		out_q.delete();
		done_cnt[0] = 0;
		done_cnt[1] = 0;
	endtask

	task automatic test_reset();
		repeat (4) @(posedge gch_clk);
		check_eq(gch_ready, 1'b0, "gch_ready during reset");
		do @(posedge gch_clk); while (gch_reset);
		check_eq(rcv0_ack, 1'b0, "rcv0_ack after reset");
		check_eq(rcv1_ack, 1'b0, "rcv1_ack after reset");
		check_eq(snd0_req, 1'b0, "snd0_req after reset");
		check_eq(gch_ready, 1'b0, "gch_ready in the first cycle after reset");
		@(posedge gch_clk);
		check_eq(gch_ready, 1'b1, "gch_ready in the second cycle after reset");
	endtask

	task automatic test_single();
		clear_test();
		sink_delay <= 0;
		make_msgs(0, 1);
		make_msgs(1, 1);
		send_queue(0, 1);
		wait_outputs(1);
		send_queue(1, 1);
		wait_outputs(2);
		check_eq(out_q[0], exp0[0], "single message from input 0");
		check_eq(out_q[1], exp1[0], "single message from input 1");
	endtask

	task automatic test_fair();
		int i;
		clear_test();
		sink_delay <= 2;
		make_msgs(0, 3);
		make_msgs(1, 3);
		fork
			send_queue(0, 3);
			send_queue(1, 3);
		join
		wait_outputs(6);
		for (i = 0; i < 6; i++)
			check_eq(out_q[i][27], i % 2, $sformatf("source of output %0d", i));
		check_by_source();
	endtask

	task automatic test_stall();
		int waited;
		clear_test();
		sink_delay <= 1;
		sink_stall <= 1'b1;
		make_msgs(0, 10);
		fork
			send_queue(0, 10);
			begin
				waited = 0;
				while (done_cnt[0] < FSZ + 1 && waited < (FSZ + 1) * MSG_CYCLES) begin
					@(posedge gch_clk);
					waited++;
				end
				repeat (4 * (REQ_CKS + ACK_CKS + 20)) @(posedge gch_clk);
				check_eq(done_cnt[0], FSZ + 1, "input handshakes before the stall");
				check_eq(out_q.size(), 0, "outputs taken while stalled");
				sink_stall <= 1'b0;
			end
		join
		wait_outputs(10);
		check_by_source();
	endtask

	task automatic test_glitch();
		int i;
		clear_test();
		sink_delay <= 0;
		@(posedge gch_clk);
		rcv1_req <= 1'b1;
		repeat (REQ_CKS - 1) @(posedge gch_clk);
		rcv1_req <= 1'b0;
		for (i = 0; i < 4 * REQ_CKS + 10; i++) begin
			@(posedge gch_clk);
			check_eq(rcv1_ack, 1'b0, "rcv1_ack after a short request pulse");
		end
		check_eq(out_q.size(), 0, "outputs after a short request pulse");
		make_msgs(1, 1);
		send_queue(1, 1);
		wait_outputs(1);
		check_by_source();
	endtask

	initial begin
		rcv0_req = 1'b0;
		rcv0_addr = '0;
		rcv0_data = '0;
		rcv0_redun = '0;
		rcv1_req = 1'b0;
		rcv1_addr = '0;
		rcv1_data = '0;
		rcv1_redun = '0;
		snd0_ack = 1'b0;
		sink_delay = 0;
		sink_stall = 1'b0;
		done_cnt[0] = 0;
		done_cnt[1] = 0;
	end

	initial begin
		forever begin
			@(posedge gch_clk);
			if (snd0_req && !snd0_ack && !sink_stall)
				sink_one();
		end
	end

	initial begin
		repeat (NUM_MSGS * MSG_CYCLES + RESET_CYCLES) @(posedge gch_clk);
		abort_run("Watchdog expired before the tests finished.");
	end

	initial begin
		test_reset();
		test_single();
		test_fair();
		test_stall();
		test_glitch();
		repeat (5) @(posedge gch_clk);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic gch_clk,
	output logic gch_reset
);

	initial begin
		gch_clk = 1'b0;
		forever #(PERIOD / 2) gch_clk = ~gch_clk;
	end

	// Reset is released on a rising edge, like every other input of the DUT.
	initial begin
		gch_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge gch_clk);
		gch_reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verilog/ns_node_top.sv
`timescale 1ns/1ns
`default_nettype none

module ns_node_top #(
	parameter int REQ_CKS = ns_pkg::NS_REQ_CKS,
	parameter int ACK_CKS = ns_pkg::NS_ACK_CKS,
	parameter int FSZ = ns_pkg::NS_FIFO_DEPTH
) (
	input  wire                gch_clk,
	input  wire                gch_reset,
	input  wire                rcv0_req,
	input  wire ns_pkg::ns_addr_t  rcv0_addr,
	input  wire ns_pkg::ns_data_t  rcv0_data,
	input  wire ns_pkg::ns_redun_t rcv0_redun,
	output logic               rcv0_ack,
	input  wire                rcv1_req,
	input  wire ns_pkg::ns_addr_t  rcv1_addr,
	input  wire ns_pkg::ns_data_t  rcv1_data,
	input  wire ns_pkg::ns_redun_t rcv1_redun,
	output logic               rcv1_ack,
	output logic               snd0_req,
	output ns_pkg::ns_addr_t   snd0_addr,
	output ns_pkg::ns_data_t   snd0_data,
	output ns_pkg::ns_redun_t  snd0_redun,
	input  wire                snd0_ack,
	output logic               gch_ready
);

	logic pend0, pend1, take0, take1;
	ns_pkg::ns_addr_t  pend0_addr, pend1_addr;
	ns_pkg::ns_data_t  pend0_data, pend1_data;
	ns_pkg::ns_redun_t pend0_redun, pend1_redun;

	ns_chnl_receiver #(.REQ_CKS(REQ_CKS)) u_rcv0 (
		.gch_clk (gch_clk), .gch_reset (gch_reset),
		.rcv_req (rcv0_req), .rcv_addr (rcv0_addr), .rcv_data (rcv0_data),
		.rcv_redun (rcv0_redun), .take (take0), .rcv_ack (rcv0_ack),
		.pend (pend0), .pend_addr (pend0_addr), .pend_data (pend0_data),
		.pend_redun (pend0_redun)
	);

	ns_chnl_receiver #(.REQ_CKS(REQ_CKS)) u_rcv1 (
		.gch_clk (gch_clk), .gch_reset (gch_reset),
		.rcv_req (rcv1_req), .rcv_addr (rcv1_addr), .rcv_data (rcv1_data),
		.rcv_redun (rcv1_redun), .take (take1), .rcv_ack (rcv1_ack),
		.pend (pend1), .pend_addr (pend1_addr), .pend_data (pend1_data),
		.pend_redun (pend1_redun)
	);

	nd_2to1 #(.FSZ(FSZ), .ACK_CKS(ACK_CKS)) u_merge (
		.gch_clk (gch_clk), .gch_reset (gch_reset),
		.pend0 (pend0), .pend0_addr (pend0_addr), .pend0_data (pend0_data),
		.pend0_redun (pend0_redun),
		.pend1 (pend1), .pend1_addr (pend1_addr), .pend1_data (pend1_data),
		.pend1_redun (pend1_redun),
		.snd0_ack (snd0_ack), .take0 (take0), .take1 (take1),
		.snd0_req (snd0_req), .snd0_addr (snd0_addr), .snd0_data (snd0_data),
		.snd0_redun (snd0_redun), .gch_ready (gch_ready)
	);

endmodule

`default_nettype wire

// File: verilog/nd_2to1.sv
`timescale 1ns/1ns
`default_nettype none

module nd_2to1 #(
	parameter int FSZ = ns_pkg::NS_FIFO_DEPTH,
	parameter int ACK_CKS = ns_pkg::NS_ACK_CKS
) (
	input  wire                gch_clk,
	input  wire                gch_reset,
	input  wire                pend0,
	input  wire ns_pkg::ns_addr_t  pend0_addr,
	input  wire ns_pkg::ns_data_t  pend0_data,
	input  wire ns_pkg::ns_redun_t pend0_redun,
	input  wire                pend1,
	input  wire ns_pkg::ns_addr_t  pend1_addr,
	input  wire ns_pkg::ns_data_t  pend1_data,
	input  wire ns_pkg::ns_redun_t pend1_redun,
	input  wire                snd0_ack,
	output logic               take0,
	output logic               take1,
	output logic               snd0_req,
	output ns_pkg::ns_addr_t   snd0_addr,
	output ns_pkg::ns_data_t   snd0_data,
	output ns_pkg::ns_redun_t  snd0_redun,
	output logic               gch_ready
);

	localparam int CW = (ACK_CKS > 1) ? $clog2(ACK_CKS) : 1;

	logic rg_rdy;
	logic choose_0;
	logic can_take, grant0, grant1;
	logic [CW-1:0] ack_cnt;
	logic ack_ckd;
	ns_pkg::ns_merge_state_t state;

	logic wr_en, rd_en, full, empty;
	ns_pkg::ns_addr_t  wr_addr, rd_addr;
	ns_pkg::ns_data_t  wr_data, rd_data;
	ns_pkg::ns_redun_t wr_redun, rd_redun;

	// No new grant while a take is in flight, since full does not yet count that write.
	assign can_take = rg_rdy && !full && !take0 && !take1;
	assign grant0 = can_take && pend0 && (!pend1 || choose_0);
	assign grant1 = can_take && pend1 && (!pend0 || !choose_0);

	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			rg_rdy <= 1'b0;
			choose_0 <= 1'b1;
			take0 <= 1'b0;
			take1 <= 1'b0;
		end else begin
			rg_rdy <= 1'b1;
			take0 <= grant0;
			take1 <= grant1;
			if (can_take && pend0 && pend1)
				choose_0 <= !choose_0; // Only a contested grant moves the turn.
		end
	end

	assign wr_en = take0 || take1;
	assign wr_addr = take1 ? pend1_addr : pend0_addr;
	assign wr_data = take1 ? pend1_data : pend0_data;
	assign wr_redun = take1 ? pend1_redun : pend0_redun;

	ns_msg_fifo #(.FSZ(FSZ)) u_bf0 (
		.gch_clk   (gch_clk),
		.gch_reset (gch_reset),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_redun  (wr_redun),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.rd_redun  (rd_redun),
		.full      (full),
		.empty     (empty)
	);

	// Ack filter, same rule as the request filter in the receivers.
	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			ack_cnt <= '0;
			ack_ckd <= 1'b0;
		end else if (snd0_ack == ack_ckd) begin
			ack_cnt <= '0;
		end else if (ack_cnt == CW'(ACK_CKS - 1)) begin
			ack_cnt <= '0;
			ack_ckd <= snd0_ack;
		end else begin
			ack_cnt <= ack_cnt + 1'b1;
		end
	end

	assign rd_en = rg_rdy && (state == ns_pkg::MS_IDLE) && !empty;

	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			state <= ns_pkg::MS_IDLE;
			snd0_req <= 1'b0;
		end else begin
			case (state)
				ns_pkg::MS_IDLE: if (rd_en) begin
					state <= ns_pkg::MS_SEND;
					snd0_req <= 1'b1;
				end
				ns_pkg::MS_SEND: if (ack_ckd) begin
					state <= ns_pkg::MS_WAIT_RELEASE;
					snd0_req <= 1'b0;
				end
				ns_pkg::MS_WAIT_RELEASE: if (!ack_ckd)
					state <= ns_pkg::MS_IDLE;
				default: state <= ns_pkg::MS_IDLE;
			endcase
		end
	end

	always_ff @(posedge gch_clk) begin
		if (rd_en) begin
			snd0_addr <= rd_addr; // Output register holds the message for the whole handshake.
			snd0_data <= rd_data;
			snd0_redun <= rd_redun;
		end
	end

	assign gch_ready = rg_rdy;

	a_one_take: assert property (@(posedge gch_clk) disable iff (gch_reset)
		!(take0 && take1));

endmodule

`default_nettype wire

// File: verilog/ns_msg_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module ns_msg_fifo #(
	parameter int FSZ = ns_pkg::NS_FIFO_DEPTH
) (
	input  wire                gch_clk,
	input  wire                gch_reset,
	input  wire                wr_en,
	input  wire ns_pkg::ns_addr_t  wr_addr,
	input  wire ns_pkg::ns_data_t  wr_data,
	input  wire ns_pkg::ns_redun_t wr_redun,
	input  wire                rd_en,
	output ns_pkg::ns_addr_t   rd_addr,
	output ns_pkg::ns_data_t   rd_data,
	output ns_pkg::ns_redun_t  rd_redun,
	output logic               full,
	output logic               empty
);

	localparam int IW = (FSZ > 1) ? $clog2(FSZ) : 1;
	localparam int CW = $clog2(FSZ + 1);

	ns_pkg::ns_addr_t  mem_addr  [FSZ];
	ns_pkg::ns_data_t  mem_data  [FSZ];
	ns_pkg::ns_redun_t mem_redun [FSZ];

	logic [IW-1:0] wr_idx;
	logic [IW-1:0] rd_idx;
	logic [CW-1:0] count;

	always_ff @(posedge gch_clk) begin
		if (wr_en) begin
			mem_addr[wr_idx] <= wr_addr;
			mem_data[wr_idx] <= wr_data;
			mem_redun[wr_idx] <= wr_redun;
		end
	end

	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			wr_idx <= '0;
			rd_idx <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_idx <= (wr_idx == IW'(FSZ - 1)) ? '0 : wr_idx + 1'b1;
			if (rd_en)
				rd_idx <= (rd_idx == IW'(FSZ - 1)) ? '0 : rd_idx + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	assign rd_addr = mem_addr[rd_idx]; // Head is always on the read port.
	assign rd_data = mem_data[rd_idx];
	assign rd_redun = mem_redun[rd_idx];

	assign full = (count == CW'(FSZ));
	assign empty = (count == '0);

	a_no_write_full: assert property (@(posedge gch_clk) disable iff (gch_reset)
		!(wr_en && full));
	a_no_read_empty: assert property (@(posedge gch_clk) disable iff (gch_reset)
		!(rd_en && empty));

endmodule

`default_nettype wire

// File: verilog/ns_chnl_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module ns_chnl_receiver #(
	parameter int REQ_CKS = ns_pkg::NS_REQ_CKS
) (
	input  wire                gch_clk,
	input  wire                gch_reset,
	input  wire                rcv_req,
	input  wire ns_pkg::ns_addr_t  rcv_addr,
	input  wire ns_pkg::ns_data_t  rcv_data,
	input  wire ns_pkg::ns_redun_t rcv_redun,
	input  wire                take,
	output logic               rcv_ack,
	output logic               pend,
	output ns_pkg::ns_addr_t   pend_addr,
	output ns_pkg::ns_data_t   pend_data,
	output ns_pkg::ns_redun_t  pend_redun
);

	localparam int CW = (REQ_CKS > 1) ? $clog2(REQ_CKS) : 1;

	logic [CW-1:0] req_cnt;
	logic req_ckd; // Filtered request level.
	logic accept;

	// The counter runs only while the raw level differs from the filtered one.
	// Any return to the old level starts the count over, so short glitches die here.
	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			req_cnt <= '0;
			req_ckd <= 1'b0;
		end else if (rcv_req == req_ckd) begin
			req_cnt <= '0;
		end else if (req_cnt == CW'(REQ_CKS - 1)) begin
			req_cnt <= '0;
			req_ckd <= rcv_req;
		end else begin
			req_cnt <= req_cnt + 1'b1;
		end
	end

	// A new message is only picked up between handshakes.
	assign accept = req_ckd && !rcv_ack && !pend;

	always_ff @(posedge gch_clk) begin
		if (gch_reset) begin
			pend <= 1'b0;
			rcv_ack <= 1'b0;
		end else if (take) begin
			pend <= 1'b0;
			rcv_ack <= 1'b1; // Message is in the FIFO now.
		end else if (rcv_ack && !req_ckd) begin
			rcv_ack <= 1'b0; // Sender has dropped req, last phase.
		end else if (accept) begin
			pend <= 1'b1;
		end
	end

	// The sender keeps the fields stable while req is high, so one capture is enough.
	always_ff @(posedge gch_clk) begin
		if (accept) begin
			pend_addr <= rcv_addr;
			pend_data <= rcv_data;
			pend_redun <= rcv_redun;
		end
	end

endmodule

`default_nettype wire

// File: verilog/ns_pkg.sv
`default_nettype none

package ns_pkg;

	// Field widths of one message.
	localparam int ASZ = 8;
	localparam int DSZ = 16;
	localparam int RSZ = 4;

	// Destination address of a message.
	typedef logic [ASZ-1:0] ns_addr_t;

	// Payload word of a message.
	typedef logic [DSZ-1:0] ns_data_t;

	// The node passes this field on untouched.
	typedef logic [RSZ-1:0] ns_redun_t;

	// A request level must hold this many cycles before a receiver sees it.
	localparam int NS_REQ_CKS = 3;

	// The same stability rule for the acknowledge on the output channel.
	localparam int NS_ACK_CKS = 3;

	// Message slots in the merger FIFO.
	localparam int NS_FIFO_DEPTH = 4;

	// Output sender of the merger.
	// MS_IDLE waits for a FIFO head, MS_SEND holds req high until the
	// filtered ack arrives, and MS_WAIT_RELEASE waits for that ack to drop.
	typedef enum logic [1:0] {
		MS_IDLE,
		MS_SEND,
		MS_WAIT_RELEASE
	} ns_merge_state_t;

endpackage

`default_nettype wire
